// File: design/algebraicBlock.sv
`timescale 1ns/10ps

module algebraicBlock import sifhPkg::*; #(
    parameter int pixW = 2
) (
    input  logic            clk,
    input  logic            res,
    input  logic            peakValid,
    input  logic [pixW-1:0] peakPixel,
    input  logic [binW-1:0] peakCH,
    output logic            wrEn,
    output logic [pixW-1:0] wrPixel,
    output logic [thW-1:0]  thMinus,
    output logic [thW-1:0]  thPlus,
    output logic [thW-1:0]  thMid
);

    logic [thW-1:0] ch;   // peak bin centre on threshold scale
    logic [thW-1:0] lo;
    logic [thW-1:0] hi;
    logic [thW:0]   sum;

    always_comb begin
        ch = (thW'(peakCH) << (thW - binW)) + thW'(binStep / 2);
        if (ch <= halfWin) begin
            // clamp at the bottom of the range
            lo = '0;
            hi = thW'(2 * halfWin);
        end else if (ch >= thMax - halfWin) begin
            // clamp at the top
            hi = thW'(thMax);
            lo = thW'(thMax - 2 * halfWin);
        end else begin
            lo = ch - thW'(halfWin);
            hi = ch + thW'(halfWin);
        end
        sum = {1'b0, lo} + {1'b0, hi};   // one extra bit for the carry
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wrEn <= 1'b0;
        end else begin
            wrEn <= peakValid;
        end
    end

    always_ff @(posedge clk) begin
        if (peakValid) begin
            wrPixel <= peakPixel;
            thMinus <= lo;
            thPlus  <= hi;
            thMid   <= sum[thW:1];   // floor of the mean
        end
    end

endmodule

// File: design/histArbiter.sv
`timescale 1ns/10ps

module histArbiter import sifhPkg::*; #(
    parameter int addrW = 6
) (
    input  logic             clk,
    input  logic             res,
    input  logic             req0,
    input  logic [addrW-1:0] addr0,
    input  logic             we0,
    input  logic [cntW-1:0]  wdata0,
    input  logic             req1,
    input  logic [addrW-1:0] addr1,
    input  logic             we1,
    input  logic [cntW-1:0]  wdata1,
    output logic             ack0,
    output logic [cntW-1:0]  rdata0,
    output logic             ack1,
    output logic [cntW-1:0]  rdata1,
    output logic             en,
    output logic             we,
    output logic [addrW-1:0] addr,
    output logic [cntW-1:0]  wdata,
    input  logic [cntW-1:0]  rdata,
    input  logic             busy
);

    typedef enum logic [1:0] {sIdle, sAccess, sRespond} stateT;

    stateT state;
    logic  lastSel;   // client served most recently
    logic  pickSel;   // client that wins in idle
    logic  selReq;

    // on a tie the client not served last goes first
    assign pickSel = (req0 && req1) ? !lastSel : req1;
    assign selReq  = lastSel ? req1 : req0;

    // ram is driven straight from the winning client in idle
    assign en    = (state == sIdle) && (req0 || req1) && !busy;
    assign we    = pickSel ? we1 : we0;
    assign addr  = pickSel ? addr1 : addr0;
    assign wdata = pickSel ? wdata1 : wdata0;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state   <= sIdle;
            lastSel <= 1'b1;   // binner wins the first tie
            ack0    <= 1'b0;
            ack1    <= 1'b0;
        end else begin
            case (state)
                sIdle: begin
                    if (en) begin
                        lastSel <= pickSel;
                        state   <= sAccess;
                    end
                end
                sAccess: begin
                    if (lastSel) begin
                        ack1 <= 1'b1;
                    end else begin
                        ack0 <= 1'b1;
                    end
                    state <= sRespond;
                end
                sRespond: begin
                    if (!selReq) begin   // client released, close handshake
                        ack0  <= 1'b0;
                        ack1  <= 1'b0;
                        state <= sIdle;
                    end
                end
                default: state <= sIdle;
            endcase
        end
    end

    // ram word is valid during access
    always_ff @(posedge clk) begin
        if (state == sAccess) begin
            if (lastSel) begin
                rdata1 <= rdata;
            end else begin
                rdata0 <= rdata;
            end
        end
    end

endmodule

// File: design/histBinner.sv
`timescale 1ns/10ps

module histBinner import sifhPkg::*; #(
    parameter int pixelNum = 4,
    localparam int pixW = $clog2(pixelNum),
    localparam int addrW = pixW + binW
) (
    input  logic             clk,
    input  logic             res,
    input  logic             evReq,
    input  logic [pixW-1:0]  evPixel,
    input  logic [binW-1:0]  evBin,
    output logic             evAck,
    output logic             req,
    output logic [addrW-1:0] addr,
    output logic             we,
    output logic [cntW-1:0]  wdata,
    input  logic             ack,
    input  logic [cntW-1:0]  rdata
);

    typedef enum logic [2:0] {sIdle, sRdPh, sRdRel, sWrPh, sWrRel, sDone} stateT;

    stateT state;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= sIdle;
            evAck <= 1'b0;
            req   <= 1'b0;
            we    <= 1'b0;
        end else begin
            case (state)
                sIdle: begin
                    if (evReq) begin
                        we    <= 1'b0;   // read the current count first
                        req   <= 1'b1;
                        state <= sRdPh;
                    end
                end
                sRdPh: begin
                    if (ack) begin
                        req   <= 1'b0;
                        state <= sRdRel;
                    end
                end
                sRdRel: begin
                    if (!ack) begin
                        we    <= 1'b1;
                        req   <= 1'b1;
                        state <= sWrPh;
                    end
                end
                sWrPh: begin
                    if (ack) begin
                        req   <= 1'b0;
                        state <= sWrRel;
                    end
                end
                sWrRel: begin
                    if (!ack) begin
                        we    <= 1'b0;
                        evAck <= 1'b1;   // bin written back
                        state <= sDone;
                    end
                end
                sDone: begin
                    if (!evReq) begin
                        evAck <= 1'b0;
                        state <= sIdle;
                    end
                end
                default: state <= sIdle;
            endcase
        end
    end

    // bin address and incremented count
    always_ff @(posedge clk) begin
        if (state == sIdle && evReq) begin
            addr <= {evPixel, evBin};
        end
        if (state == sRdPh && ack) begin
            wdata <= (rdata == {cntW{1'b1}}) ? rdata : rdata + 1'b1;   // saturate
        end
    end

endmodule

// File: design/histRam.sv
`timescale 1ns/10ps

module histRam import sifhPkg::*; #(
    parameter int pixelNum = 4,
    localparam int depth = pixelNum * binNum,
    localparam int addrW = $clog2(depth)
) (
    input  logic             clk,
    input  logic             res,
    input  logic             en,
    input  logic             we,
    input  logic [addrW-1:0] addr,
    input  logic [cntW-1:0]  wdata,
    output logic [cntW-1:0]  rdata,
    output logic             busy
);

    logic [cntW-1:0]  mem [depth];
    logic [addrW-1:0] clrAddr;   // walks the array after reset

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            busy    <= 1'b1;
            clrAddr <= '0;
        end else if (busy) begin
            clrAddr <= clrAddr + 1'b1;
            if (clrAddr == addrW'(depth - 1)) begin
                busy <= 1'b0;   // last word zeroed
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            mem[clrAddr] <= '0;
        end else if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// File: design/peakSearch.sv
`timescale 1ns/10ps

module peakSearch import sifhPkg::*; #(
    parameter int pixelNum = 4,
    localparam int pixW = $clog2(pixelNum),
    localparam int addrW = pixW + binW
) (
    input  logic             clk,
    input  logic             res,
    input  logic             frameReq,
    output logic             frameAck,
    output logic             req,
    output logic [addrW-1:0] addr,
    output logic             we,
    output logic [cntW-1:0]  wdata,
    input  logic             ack,
    input  logic [cntW-1:0]  rdata,
    output logic             peakValid,
    output logic [pixW-1:0]  peakPixel,
    output logic [binW-1:0]  peakCH
);

    typedef enum logic [2:0] {
        sIdle, sRdPh, sRdRel, sWrPh, sWrRel, sNextPix, sTail, sDone
    } stateT;

    stateT           state;
    logic [pixW-1:0] pix;
    logic [binW-1:0] bin;
    logic [cntW-1:0] bestCnt;
    logic [binW-1:0] bestBin;

    assign addr  = {pix, bin};
    assign wdata = '0;   // every bin is cleared after its read

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= sIdle;
            frameAck  <= 1'b0;
            req       <= 1'b0;
            we        <= 1'b0;
            peakValid <= 1'b0;
            pix       <= '0;
            bin       <= '0;
            bestCnt   <= '0;
            bestBin   <= '0;
        end else begin
            case (state)
                sIdle: begin
                    if (frameReq) begin
                        pix     <= '0;
                        bin     <= '0;
                        bestCnt <= '0;
                        bestBin <= '0;
                        req     <= 1'b1;
                        state   <= sRdPh;
                    end
                end
                sRdPh: begin
                    if (ack) begin
                        req <= 1'b0;
                        if (rdata > bestCnt) begin   // strict, ties keep lower bin
                            bestCnt <= rdata;
                            bestBin <= bin;
                        end
                        state <= sRdRel;
                    end
                end
                sRdRel: begin
                    if (!ack) begin
                        we    <= 1'b1;
                        req   <= 1'b1;
                        state <= sWrPh;
                    end
                end
                sWrPh: begin
                    if (ack) begin
                        req   <= 1'b0;
                        state <= sWrRel;
                    end
                end
                sWrRel: begin
                    if (!ack) begin
                        we <= 1'b0;
                        if (bin == binW'(binNum - 1)) begin
                            peakValid <= 1'b1;
                            state     <= sNextPix;
                        end else begin
                            bin   <= bin + 1'b1;
                            req   <= 1'b1;
                            state <= sRdPh;
                        end
                    end
                end
                sNextPix: begin
                    peakValid <= 1'b0;
                    if (pix == pixW'(pixelNum - 1)) begin
                        state <= sTail;
                    end else begin
                        pix     <= pix + 1'b1;
                        bin     <= '0;
                        bestCnt <= '0;
                        bestBin <= '0;
                        req     <= 1'b1;
                        state   <= sRdPh;
                    end
                end
                sTail: begin
                    // last table write lands on this edge
                    frameAck <= 1'b1;
                    state    <= sDone;
                end
                sDone: begin
                    if (!frameReq) begin
                        frameAck <= 1'b0;
                        state    <= sIdle;
                    end
                end
                default: state <= sIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == sWrRel && !ack && bin == binW'(binNum - 1)) begin
            peakPixel <= pix;
            peakCH    <= bestBin;
        end
    end

endmodule

// File: design/sifhPkg.sv
package sifhPkg;

    // bin index width, 16 bins per pixel
    localparam int binW = 4;
    localparam int binNum = 2 ** binW;

    // threshold scale
    localparam int thW = 8;
    localparam int thMax = 2 ** thW - 1;

    // one bin expressed on the threshold scale
    localparam int binStep = 2 ** (thW - binW);

    // half of the detection window, one and a half bins
    localparam int halfWin = binStep + binStep / 2;

    // histogram counts saturate at all ones
    localparam int cntW = 8;

endpackage

// File: design/sifhTop.sv
`timescale 1ns/10ps

module sifhTop import sifhPkg::*; #(
    parameter int pixelNum = 4,
    localparam int pixW = $clog2(pixelNum),
    localparam int addrW = pixW + binW
) (
    input  logic            clk,
    input  logic            res,
    input  logic            evReq,
    input  logic [pixW-1:0] evPixel,
    input  logic [binW-1:0] evBin,
    output logic            evAck,
    input  logic            frameReq,
    output logic            frameAck,
    input  logic [pixW-1:0] rdPixel,
    output logic [thW-1:0]  rdThMinus,
    output logic [thW-1:0]  rdThPlus,
    output logic [thW-1:0]  rdThMid
);

    // binner side of the arbiter
    logic             binReq, binWe, binAck;
    logic [addrW-1:0] binAddr;
    logic [cntW-1:0]  binWdata, binRdata;

    // peak search side
    logic             srchReq, srchWe, srchAck;
    logic [addrW-1:0] srchAddr;
    logic [cntW-1:0]  srchWdata, srchRdata;

    logic             ramEn, ramWe, ramBusy;
    logic [addrW-1:0] ramAddr;
    logic [cntW-1:0]  ramWdata, ramRdata;

    logic             peakValid;
    logic [pixW-1:0]  peakPixel;
    logic [binW-1:0]  peakCH;

    logic             wrEn;
    logic [pixW-1:0]  wrPixel;
    logic [thW-1:0]   thMinus, thPlus, thMid;

    histRam #(.pixelNum(pixelNum)) uRam (
        .clk(clk), .res(res), .en(ramEn), .we(ramWe), .addr(ramAddr),
        .wdata(ramWdata), .rdata(ramRdata), .busy(ramBusy)
    );

    histArbiter #(.addrW(addrW)) uArb (
        .clk(clk), .res(res),
        .req0(binReq), .addr0(binAddr), .we0(binWe), .wdata0(binWdata),
        .req1(srchReq), .addr1(srchAddr), .we1(srchWe), .wdata1(srchWdata),
        .ack0(binAck), .rdata0(binRdata), .ack1(srchAck), .rdata1(srchRdata),
        .en(ramEn), .we(ramWe), .addr(ramAddr), .wdata(ramWdata),
        .rdata(ramRdata), .busy(ramBusy)
    );

    histBinner #(.pixelNum(pixelNum)) uBinner (
        .clk(clk), .res(res), .evReq(evReq), .evPixel(evPixel), .evBin(evBin),
        .evAck(evAck), .req(binReq), .addr(binAddr), .we(binWe),
        .wdata(binWdata), .ack(binAck), .rdata(binRdata)
    );

    peakSearch #(.pixelNum(pixelNum)) uSearch (
        .clk(clk), .res(res), .frameReq(frameReq), .frameAck(frameAck),
        .req(srchReq), .addr(srchAddr), .we(srchWe), .wdata(srchWdata),
        .ack(srchAck), .rdata(srchRdata), .peakValid(peakValid),
        .peakPixel(peakPixel), .peakCH(peakCH)
    );

    algebraicBlock #(.pixW(pixW)) uAlg (
        .clk(clk), .res(res), .peakValid(peakValid), .peakPixel(peakPixel),
        .peakCH(peakCH), .wrEn(wrEn), .wrPixel(wrPixel), .thMinus(thMinus),
        .thPlus(thPlus), .thMid(thMid)
    );

    thresholdTable #(.pixelNum(pixelNum)) uTable (
        .clk(clk), .res(res), .wrEn(wrEn), .wrPixel(wrPixel),
        .thMinus(thMinus), .thPlus(thPlus), .thMid(thMid), .rdPixel(rdPixel),
        .rdThMinus(rdThMinus), .rdThPlus(rdThPlus), .rdThMid(rdThMid)
    );

endmodule

// File: design/thresholdTable.sv
`timescale 1ns/10ps

module thresholdTable import sifhPkg::*; #(
    parameter int pixelNum = 4,
    localparam int pixW = $clog2(pixelNum)
) (
    input  logic            clk,
    input  logic            res,
    input  logic            wrEn,
    input  logic [pixW-1:0] wrPixel,
    input  logic [thW-1:0]  thMinus,
    input  logic [thW-1:0]  thPlus,
    input  logic [thW-1:0]  thMid,
    input  logic [pixW-1:0] rdPixel,
    output logic [thW-1:0]  rdThMinus,
    output logic [thW-1:0]  rdThPlus,
    output logic [thW-1:0]  rdThMid
);

    logic [thW-1:0] minusTab [pixelNum];
    logic [thW-1:0] plusTab  [pixelNum];
    logic [thW-1:0] midTab   [pixelNum];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int i = 0; i < pixelNum; i++) begin
                minusTab[i] <= '0;
                plusTab[i]  <= '0;
                midTab[i]   <= '0;
            end
            rdThMinus <= '0;
            rdThPlus  <= '0;
            rdThMid   <= '0;
        end else begin
            if (wrEn) begin
                minusTab[wrPixel] <= thMinus;
                plusTab[wrPixel]  <= thPlus;
                midTab[wrPixel]   <= thMid;
            end
            // read returns the old entry on a same-cycle write
            rdThMinus <= minusTab[rdPixel];
            rdThPlus  <= plusTab[rdPixel];
            rdThMid   <= midTab[rdPixel];
        end
    end

endmodule

// File: dv/sifhTb.sv
`timescale 1ns/10ps

module sifhTb import sifhPkg::*; ();

    localparam int pixelNum = 4;
    localparam int pixW = $clog2(pixelNum);
    localparam int maxCnt = 2 ** cntW - 1;
    // watchdog budget, 400 cycles per event and 200 per bin of a frame
    localparam int evBudget = 560;
    localparam int frameBudget = 6;
    localparam int limitCycles = evBudget * 400 + frameBudget * pixelNum * binNum * 200 + 1000;

    logic            clk;
    logic            res;
    logic            evReq;
    logic [pixW-1:0] evPixel;
    logic [binW-1:0] evBin;
    logic            evAck;
    logic            frameReq;
    logic            frameAck;
    logic [pixW-1:0] rdPixel;
    logic [thW-1:0]  rdThMinus;
    logic [thW-1:0]  rdThPlus;
    logic [thW-1:0]  rdThMid;

    logic [31:0] rngState;
    int          cnt [pixelNum][binNum];   // model histogram, saturating
    int          expMinus [pixelNum];
    int          expPlus [pixelNum];
    int          expMid [pixelNum];

    sifhTop #(.pixelNum(pixelNum)) dut (
        .clk(clk), .res(res), .evReq(evReq), .evPixel(evPixel), .evBin(evBin),
        .evAck(evAck), .frameReq(frameReq), .frameAck(frameAck), .rdPixel(rdPixel),
        .rdThMinus(rdThMinus), .rdThPlus(rdThPlus), .rdThMid(rdThMid)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: actual 0x%0h, expected 0x%0h", name, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // one photon event through the four-phase handshake
    task automatic sendEvent(input int pix, input int bin);
        @(negedge clk);
        evPixel = pixW'(pix);
        evBin   = binW'(bin);
        evReq   = 1'b1;
        @(negedge clk);
        while (!evAck) @(negedge clk);
        evReq = 1'b0;
        while (evAck) @(negedge clk);
        if (cnt[pix][bin] < maxCnt) begin
            cnt[pix][bin]++;
        end
    endtask

    task automatic checkTable();
        for (int p = 0; p < pixelNum; p++) begin
            @(negedge clk);
            rdPixel = pixW'(p);
            @(negedge clk);   // registered read has landed
            checkValue($sformatf("rdThMinus[%0d]", p), rdThMinus, expMinus[p]);
            checkValue($sformatf("rdThPlus[%0d]", p), rdThPlus, expPlus[p]);
            checkValue($sformatf("rdThMid[%0d]", p), rdThMid, expMid[p]);
        end
    endtask

    // frame end, then model search and window per pixel
    task automatic runFrame();
        int best;
        int peak;
        int ch;
        @(negedge clk);
        frameReq = 1'b1;
        @(negedge clk);
        while (!frameAck) @(negedge clk);
        frameReq = 1'b0;
        while (frameAck) @(negedge clk);
        for (int p = 0; p < pixelNum; p++) begin
            best = 0;
            peak = 0;
            for (int b = 0; b < binNum; b++) begin
                if (cnt[p][b] > best) begin   // ties keep the lower bin
                    best = cnt[p][b];
                    peak = b;
                end
                cnt[p][b] = 0;   // cleared by the search
            end
            ch = peak * binStep + binStep / 2;
            if (ch <= halfWin) begin
                expMinus[p] = 0;
                expPlus[p]  = 2 * halfWin;
            end else if (ch >= thMax - halfWin) begin
                expPlus[p]  = thMax;
                expMinus[p] = thMax - 2 * halfWin;
            end else begin
                expMinus[p] = ch - halfWin;
                expPlus[p]  = ch + halfWin;
            end
            expMid[p] = (expMinus[p] + expPlus[p]) / 2;
        end
        checkTable();
    endtask

    task automatic randomFrame();
        int n;
        int pix;
        int bin;
        n = 50 + int'((nextRand() >> 16) % 21);
        for (int i = 0; i < n; i++) begin
            pix = int'((nextRand() >> 16) % pixelNum);
            bin = int'((nextRand() >> 20) % binNum);
            sendEvent(pix, bin);
        end
        runFrame();
    endtask

    initial begin
        rngState = 32'h3be0;
        res      = 1'b0;
        evReq    = 1'b0;
        evPixel  = '0;
        evBin    = '0;
        frameReq = 1'b0;
        rdPixel  = '0;
        for (int p = 0; p < pixelNum; p++) begin
            expMinus[p] = 0;
            expPlus[p]  = 0;
            expMid[p]   = 0;
            for (int b = 0; b < binNum; b++) begin
                cnt[p][b] = 0;
            end
        end
        repeat (2) @(negedge clk);
        res = 1'b1;

        checkValue("evAck", evAck, 0);
        checkValue("frameAck", frameAck, 0);
        checkTable();   // empty table after reset

        randomFrame();

        // windows clamped at both ends of the range
        repeat (5) sendEvent(0, 0);
        repeat (5) sendEvent(1, binNum - 1);
        repeat (3) sendEvent(2, 14);
        repeat (2) sendEvent(3, 1);
        runFrame();

        // ties and an empty pixel
        for (int i = 0; i < 3; i++) begin
            sendEvent(0, 9);
            sendEvent(0, 5);
        end
        for (int i = 0; i < 4; i++) begin
            sendEvent(1, 12);
            sendEvent(1, 2);
        end
        sendEvent(3, 10);
        runFrame();

        randomFrame();   // only this frame's events count

        // 300 wraps to 44 without saturation, so bin 9 would win
        repeat (300) sendEvent(2, 6);
        repeat (60) sendEvent(2, 9);
        sendEvent(1, 4);
        runFrame();

        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin
        repeat (limitCycles) @(posedge clk);
        $display("timeout: the DUT stopped answering its handshakes, the run hung");
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: sifhTop.f
design/sifhPkg.sv
design/histRam.sv
design/histArbiter.sv
design/histBinner.sv
design/peakSearch.sv
design/algebraicBlock.sv
design/thresholdTable.sv
design/sifhTop.sv
dv/sifhTb.sv
